// File: dmem_pipe.f
+incdir+logic
+incdir+verif
logic/mem_op_pkg.sv
logic/mem_stage_pkg.sv
logic/stage_if.sv
logic/op_decode.sv
logic/word_mem.sv
logic/load_amo_unit.sv
logic/dmem_pipe.sv
verif/dmem_pipe_tb.sv

// File: logic/dmem_defines.svh
`ifndef DMEM_DEFINES_SVH
`define DMEM_DEFINES_SVH

// Byte address into the array
`define DMEM_ADDR_WIDTH 10

// Lane logic assumes four byte lanes
`define DMEM_DATA_WIDTH 32

// Must equal 2**(DMEM_ADDR_WIDTH-2)
`define DMEM_WORDS 256

`endif

// File: logic/dmem_pipe.sv
`include "dmem_defines.svh"

module dmem_pipe (
  input  logic                          clk_i,
  input  logic                          reset_i,
  input  logic                          req_v_i,
  input  logic [4:0]                    req_opcode_i,
  input  logic [`DMEM_ADDR_WIDTH-1:0]   req_addr_i,
  input  logic [`DMEM_DATA_WIDTH-1:0]   req_data_i,
  input  logic [`DMEM_DATA_WIDTH/8-1:0] req_mask_i,
  output logic                          resp_v_o,
  output logic [`DMEM_DATA_WIDTH-1:0]   resp_data_o
);

  mem_op_pkg::mem_req_s req;

  logic                          wr_en;
  logic [`DMEM_ADDR_WIDTH-3:0]   wr_addr;
  logic [`DMEM_DATA_WIDTH-1:0]   wr_data;
  logic [`DMEM_DATA_WIDTH/8-1:0] wr_mask;

  assign req.opcode = mem_op_pkg::opcode_e'(req_opcode_i);
  assign req.addr   = req_addr_i;
  assign req.data   = req_data_i;
  assign req.mask   = req_mask_i;

  stage_if #(.payload_t(mem_stage_pkg::dec_op_s)) dec_if ();
  stage_if #(.payload_t(mem_stage_pkg::rd_op_s))  rd_if ();

  op_decode u_decode (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .req_v_i (req_v_i),
    .req_i   (req),
    .dec_o   (dec_if)
  );

  word_mem u_mem (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .dec_i     (dec_if),
    .rd_o      (rd_if),
    .wr_en_i   (wr_en),
    .wr_addr_i (wr_addr),
    .wr_data_i (wr_data),
    .wr_mask_i (wr_mask)
  );

  // Execute stage also owns the write-back into u_mem
  load_amo_unit u_exec (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .rd_i        (rd_if),
    .wr_en_o     (wr_en),
    .wr_addr_o   (wr_addr),
    .wr_data_o   (wr_data),
    .wr_mask_o   (wr_mask),
    .resp_v_o    (resp_v_o),
    .resp_data_o (resp_data_o)
  );

endmodule

// File: logic/load_amo_unit.sv
`include "dmem_defines.svh"

module load_amo_unit (
  input  logic                          clk_i,
  input  logic                          reset_i,
  stage_if.consumer                     rd_i,
  output logic                          wr_en_o,
  output logic [`DMEM_ADDR_WIDTH-3:0]   wr_addr_o,
  output logic [`DMEM_DATA_WIDTH-1:0]   wr_data_o,
  output logic [`DMEM_DATA_WIDTH/8-1:0] wr_mask_o,
  output logic                          resp_v_o,
  output logic [`DMEM_DATA_WIDTH-1:0]   resp_data_o
);

  mem_stage_pkg::rd_op_s       rd;
  logic [`DMEM_DATA_WIDTH-1:0] old_word;
  logic [`DMEM_DATA_WIDTH-1:0] src;
  logic [7:0]                  byte_sel;
  logic [15:0]                 half_sel;
  logic [`DMEM_DATA_WIDTH-1:0] lane_mask;
  logic [`DMEM_DATA_WIDTH-1:0] load_data;
  logic [`DMEM_DATA_WIDTH-1:0] amo_word;
  logic [`DMEM_DATA_WIDTH-1:0] resp_d;

  assign rd       = rd_i.payload;
  assign old_word = rd.rd_data;
  assign src      = rd.op.req_data;

  ////////////////////
  // Load extraction

  assign byte_sel = old_word[8*rd.op.byte_ofs+:8];
  assign half_sel = rd.op.byte_ofs[1] ? old_word[31:16] : old_word[15:0];

  always_comb begin
    for (int i = 0; i < `DMEM_DATA_WIDTH/8; i++) begin
      lane_mask[8*i+:8] = {8{rd.op.byte_mask[i]}};
    end
  end

  always_comb begin
    case (rd.op.load_kind)
      mem_stage_pkg::LD_HALF_S: load_data = {{16{half_sel[15]}}, half_sel};
      mem_stage_pkg::LD_HALF_U: load_data = {16'b0, half_sel};
      mem_stage_pkg::LD_BYTE_S: load_data = {{24{byte_sel[7]}}, byte_sel};
      mem_stage_pkg::LD_BYTE_U: load_data = {24'b0, byte_sel};
      mem_stage_pkg::LD_MASK:   load_data = old_word & lane_mask;
      default:                  load_data = old_word;
    endcase
  end

  ////////////////////
  // Atomic new word

  always_comb begin
    case (rd.op.opcode)
      mem_op_pkg::AMOADD_W:  amo_word = old_word + src;
      mem_op_pkg::AMOXOR_W:  amo_word = old_word ^ src;
      mem_op_pkg::AMOAND_W:  amo_word = old_word & src;
      mem_op_pkg::AMOOR_W:   amo_word = old_word | src;
      mem_op_pkg::AMOMIN_W:  amo_word = ($signed(src) < $signed(old_word)) ? src : old_word;
      mem_op_pkg::AMOMAX_W:  amo_word = ($signed(src) > $signed(old_word)) ? src : old_word;
      mem_op_pkg::AMOMINU_W: amo_word = (src < old_word) ? src : old_word;
      mem_op_pkg::AMOMAXU_W: amo_word = (src > old_word) ? src : old_word;
      default:               amo_word = src;  // Swap
    endcase
  end

  // Write port, committed by word_mem at the end of this cycle
  assign wr_en_o   = rd_i.valid && (rd.op.op_class != mem_stage_pkg::OP_LOAD);
  assign wr_addr_o = rd.op.word_addr;
  assign wr_data_o = (rd.op.op_class == mem_stage_pkg::OP_AMO) ? amo_word : rd.op.store_data;
  assign wr_mask_o = (rd.op.op_class == mem_stage_pkg::OP_AMO) ? 4'b1111 : rd.op.byte_mask;

  always_comb begin
    case (rd.op.op_class)
      mem_stage_pkg::OP_LOAD: resp_d = load_data;
      mem_stage_pkg::OP_AMO:  resp_d = old_word;
      default:                resp_d = '0;  // Stores answer zero
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      resp_v_o <= 1'b0;
    end else begin
      resp_v_o <= rd_i.valid;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rd_i.valid) begin
      resp_data_o <= resp_d;
    end
  end

endmodule

// File: logic/mem_op_pkg.sv
`include "dmem_defines.svh"

package mem_op_pkg;

  typedef enum logic [4:0] {
    LB        = 5'd0,
    LH        = 5'd1,
    LW        = 5'd2,
    LBU       = 5'd3,
    LHU       = 5'd4,
    LM        = 5'd5,
    SB        = 5'd6,
    SH        = 5'd7,
    SW        = 5'd8,
    SM        = 5'd9,
    AMOSWAP_W = 5'd10,
    AMOADD_W  = 5'd11,
    AMOXOR_W  = 5'd12,
    AMOAND_W  = 5'd13,
    AMOOR_W   = 5'd14,
    AMOMIN_W  = 5'd15,
    AMOMAX_W  = 5'd16,
    AMOMINU_W = 5'd17,
    AMOMAXU_W = 5'd18
  } opcode_e;

  // Request packet as presented at the port
  typedef struct packed {
    opcode_e                       opcode;
    logic [`DMEM_ADDR_WIDTH-1:0]   addr;   // Byte address
    logic [`DMEM_DATA_WIDTH-1:0]   data;
    logic [`DMEM_DATA_WIDTH/8-1:0] mask;   // Used by SM and LM
  } mem_req_s;

endpackage

// File: logic/mem_stage_pkg.sv
`include "dmem_defines.svh"

package mem_stage_pkg;

  typedef enum logic [1:0] {
    OP_LOAD  = 2'd0,
    OP_STORE = 2'd1,
    OP_AMO   = 2'd2
  } op_class_e;

  typedef enum logic [2:0] {
    LD_WORD   = 3'd0,
    LD_HALF_S = 3'd1,
    LD_HALF_U = 3'd2,
    LD_BYTE_S = 3'd3,
    LD_BYTE_U = 3'd4,
    LD_MASK   = 3'd5
  } load_kind_e;

  // Decode to memory stage
  typedef struct packed {
    op_class_e                     op_class;
    load_kind_e                    load_kind;
    mem_op_pkg::opcode_e           opcode;
    logic [`DMEM_ADDR_WIDTH-3:0]   word_addr;
    logic [1:0]                    byte_ofs;
    logic [`DMEM_DATA_WIDTH-1:0]   store_data;  // Replicated across lanes
    logic [`DMEM_DATA_WIDTH/8-1:0] byte_mask;
    logic [`DMEM_DATA_WIDTH-1:0]   req_data;    // Atomic operand
  } dec_op_s;

  // Memory to execute stage
  typedef struct packed {
    dec_op_s                     op;
    logic [`DMEM_DATA_WIDTH-1:0] rd_data;
  } rd_op_s;

endpackage

// File: logic/op_decode.sv
`include "dmem_defines.svh"

module op_decode (
  input  logic                 clk_i,
  input  logic                 reset_i,
  input  logic                 req_v_i,
  input  mem_op_pkg::mem_req_s req_i,
  stage_if.producer            dec_o
);

  mem_stage_pkg::dec_op_s dec_d;
  logic [1:0]             ofs;

  assign ofs = req_i.addr[1:0];

  always_comb begin
    dec_d            = '0;
    dec_d.opcode     = req_i.opcode;
    dec_d.word_addr  = req_i.addr[`DMEM_ADDR_WIDTH-1:2];
    dec_d.byte_ofs   = ofs;
    dec_d.req_data   = req_i.data;
    dec_d.op_class   = mem_stage_pkg::OP_LOAD;
    dec_d.load_kind  = mem_stage_pkg::LD_WORD;  // Also covers unknown opcodes
    case (req_i.opcode)
      mem_op_pkg::LH:  dec_d.load_kind = mem_stage_pkg::LD_HALF_S;
      mem_op_pkg::LHU: dec_d.load_kind = mem_stage_pkg::LD_HALF_U;
      mem_op_pkg::LB:  dec_d.load_kind = mem_stage_pkg::LD_BYTE_S;
      mem_op_pkg::LBU: dec_d.load_kind = mem_stage_pkg::LD_BYTE_U;
      mem_op_pkg::LM: begin
        dec_d.load_kind = mem_stage_pkg::LD_MASK;
        dec_d.byte_mask = req_i.mask;  // Lane select for the load, never written
      end
      mem_op_pkg::SW, mem_op_pkg::SM: begin
        dec_d.op_class   = mem_stage_pkg::OP_STORE;
        dec_d.store_data = req_i.data;
        dec_d.byte_mask  = (req_i.opcode == mem_op_pkg::SW) ? 4'b1111 : req_i.mask;
      end
      mem_op_pkg::SH: begin
        dec_d.op_class   = mem_stage_pkg::OP_STORE;
        dec_d.store_data = {2{req_i.data[15:0]}};
        dec_d.byte_mask  = ofs[1] ? 4'b1100 : 4'b0011;  // Bit 0 ignored
      end
      mem_op_pkg::SB: begin
        dec_d.op_class   = mem_stage_pkg::OP_STORE;
        dec_d.store_data = {4{req_i.data[7:0]}};
        dec_d.byte_mask  = 4'b0001 << ofs;
      end
      mem_op_pkg::AMOSWAP_W, mem_op_pkg::AMOADD_W, mem_op_pkg::AMOXOR_W,
      mem_op_pkg::AMOAND_W, mem_op_pkg::AMOOR_W, mem_op_pkg::AMOMIN_W,
      mem_op_pkg::AMOMAX_W, mem_op_pkg::AMOMINU_W, mem_op_pkg::AMOMAXU_W: begin
        dec_d.op_class = mem_stage_pkg::OP_AMO;
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      dec_o.valid <= 1'b0;
    end else begin
      dec_o.valid <= req_v_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_v_i) begin
      dec_o.payload <= dec_d;
    end
  end

endmodule

// File: logic/stage_if.sv
// One registered pipeline link, no back-pressure
interface stage_if #(
  parameter type payload_t = logic
);

  logic     valid;
  payload_t payload;

  modport producer (
    output valid,
    output payload
  );

  modport consumer (
    input valid,
    input payload
  );

endinterface

// File: logic/word_mem.sv
`include "dmem_defines.svh"

module word_mem (
  input  logic                              clk_i,
  input  logic                              reset_i,
  stage_if.consumer                         dec_i,
  stage_if.producer                         rd_o,
  input  logic                              wr_en_i,
  input  logic [`DMEM_ADDR_WIDTH-3:0]       wr_addr_i,
  input  logic [`DMEM_DATA_WIDTH-1:0]       wr_data_i,
  input  logic [`DMEM_DATA_WIDTH/8-1:0]     wr_mask_i
);

  logic [`DMEM_DATA_WIDTH-1:0] mem [`DMEM_WORDS];

  mem_stage_pkg::dec_op_s      dec;
  logic [`DMEM_DATA_WIDTH-1:0] rd_word;
  logic                        fwd_hit;

  assign dec = dec_i.payload;

  ////////////////////
  // Read with forwarding

  // Stage 3 writes at the same edge this read is captured
  assign fwd_hit = wr_en_i && (wr_addr_i == dec.word_addr);

  always_comb begin
    rd_word = mem[dec.word_addr];
    if (fwd_hit) begin
      for (int i = 0; i < `DMEM_DATA_WIDTH/8; i++) begin
        if (wr_mask_i[i]) begin
          rd_word[8*i+:8] = wr_data_i[8*i+:8];
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rd_o.valid <= 1'b0;
    end else begin
      rd_o.valid <= dec_i.valid;
    end
  end

  always_ff @(posedge clk_i) begin
    if (dec_i.valid) begin
      rd_o.payload.op      <= dec;
      rd_o.payload.rd_data <= rd_word;
    end
  end

  ////////////////////
  // Write port

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int w = 0; w < `DMEM_WORDS; w++) begin
        mem[w] <= '0;
      end
    end else if (wr_en_i) begin
      for (int i = 0; i < `DMEM_DATA_WIDTH/8; i++) begin
        if (wr_mask_i[i]) begin
          mem[wr_addr_i][8*i+:8] <= wr_data_i[8*i+:8];  // Byte lane i
        end
      end
    end
  end

endmodule

// File: run_sim.sh
#!/bin/sh
# Build the dmem_pipe testbench with Verilator, run it, and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal -f dmem_pipe.f --top-module dmem_pipe_tb \
  || { echo "Verilator build failed"; exit 1; }
out=$(./obj_dir/Vdmem_pipe_tb) ; echo "$out"
echo "$out" | grep -qx "Simulation passed" && exit 0 || exit 1

// File: verif/dmem_ref.svh
`ifndef DMEM_REF_SVH
`define DMEM_REF_SVH

// Shadow copy of the array, updated in program order as requests are issued
logic [`DMEM_DATA_WIDTH-1:0] shadow [`DMEM_WORDS];

function automatic logic [31:0] byte_merge(input logic [31:0] old_w,
                                           input logic [31:0] new_w,
                                           input logic [3:0]  be);
  logic [31:0] res;
  res = old_w;
  for (int i = 0; i < 4; i++) begin
    if (be[i]) res[8*i+:8] = new_w[8*i+:8];
  end
  return res;
endfunction

// Expected response for one request; the shadow word is updated at once
function automatic logic [31:0] model_access(input mem_op_pkg::opcode_e          op,
                                             input logic [`DMEM_ADDR_WIDTH-1:0] addr,
                                             input logic [31:0]                 data,
                                             input logic [3:0]                  mask);
  logic [`DMEM_ADDR_WIDTH-3:0] idx;
  logic [31:0] old_w;
  logic [31:0] nw;
  logic [31:0] resp;
  logic [31:0] lm;
  logic [7:0]  b;
  logic [15:0] h;
  idx   = addr[`DMEM_ADDR_WIDTH-1:2];
  old_w = shadow[idx];
  b     = old_w[8*addr[1:0]+:8];
  h     = addr[1] ? old_w[31:16] : old_w[15:0];  // Bit 0 ignored
  nw    = old_w;
  resp  = 32'h0;  // Stores answer zero
  for (int i = 0; i < 4; i++) lm[8*i+:8] = mask[i] ? 8'hff : 8'h00;
  case (op)
    mem_op_pkg::LW:        resp = old_w;
    mem_op_pkg::LB:        resp = {{24{b[7]}}, b};
    mem_op_pkg::LBU:       resp = {24'h0, b};
    mem_op_pkg::LH:        resp = {{16{h[15]}}, h};
    mem_op_pkg::LHU:       resp = {16'h0, h};
    mem_op_pkg::LM:        resp = old_w & lm;
    mem_op_pkg::SW:        nw = data;
    mem_op_pkg::SM:        nw = byte_merge(old_w, data, mask);
    mem_op_pkg::SH:        nw = byte_merge(old_w, {2{data[15:0]}}, addr[1] ? 4'b1100 : 4'b0011);
    mem_op_pkg::SB:        nw = byte_merge(old_w, {4{data[7:0]}}, 4'b0001 << addr[1:0]);
    default: begin
      resp = old_w;  // Atomics return the old word
      case (op)
        mem_op_pkg::AMOSWAP_W: nw = data;
        mem_op_pkg::AMOADD_W:  nw = old_w + data;
        mem_op_pkg::AMOXOR_W:  nw = old_w ^ data;
        mem_op_pkg::AMOAND_W:  nw = old_w & data;
        mem_op_pkg::AMOOR_W:   nw = old_w | data;
        // Signed order equals unsigned order with the sign bits flipped
        mem_op_pkg::AMOMIN_W:  nw = ((data ^ 32'h8000_0000) < (old_w ^ 32'h8000_0000)) ? data : old_w;
        mem_op_pkg::AMOMAX_W:  nw = ((data ^ 32'h8000_0000) > (old_w ^ 32'h8000_0000)) ? data : old_w;
        mem_op_pkg::AMOMINU_W: nw = (data < old_w) ? data : old_w;
        default:               nw = (data > old_w) ? data : old_w;  // AMOMAXU_W
      endcase
    end
  endcase
  shadow[idx] = nw;
  return resp;
endfunction

`endif

// File: verif/dmem_pipe_tb.sv
`include "dmem_defines.svh"

module dmem_pipe_tb;

  localparam int RAND_REQS  = 2000;
  localparam int DIR_BOUND  = 200;                       // Upper bound on directed requests
  localparam int MAX_CYCLES = DIR_BOUND + 2 * RAND_REQS + 20;  // Random phase idles ~30%
  localparam logic [`DMEM_ADDR_WIDTH-1:0] WIN = 10'h140;  // Base of the 8-word window

  logic                          clk_i = 1'b0;
  logic                          reset_i;
  logic                          req_v_i;
  logic [4:0]                    req_opcode_i;
  logic [`DMEM_ADDR_WIDTH-1:0]   req_addr_i;
  logic [`DMEM_DATA_WIDTH-1:0]   req_data_i;
  logic [`DMEM_DATA_WIDTH/8-1:0] req_mask_i;
  logic                          resp_v_o;
  logic [`DMEM_DATA_WIDTH-1:0]   resp_data_o;

  logic [31:0] exp_q [$];
  int          due_q [$];
  logic [31:0] exp_data;
  int          exp_due;
  int          cycle = 0;
  int          value_errors = 0;
  int          protocol_errors = 0;
  int          checked = 0;
  logic [31:0] rng = 32'h9792_a7e7;

  mem_op_pkg::opcode_e amo_ops [9] = '{mem_op_pkg::AMOSWAP_W, mem_op_pkg::AMOADD_W,
    mem_op_pkg::AMOXOR_W, mem_op_pkg::AMOAND_W, mem_op_pkg::AMOOR_W, mem_op_pkg::AMOMIN_W,
    mem_op_pkg::AMOMAX_W, mem_op_pkg::AMOMINU_W, mem_op_pkg::AMOMAXU_W};

  `include "dmem_ref.svh"

  dmem_pipe dut (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .req_v_i      (req_v_i),
    .req_opcode_i (req_opcode_i),
    .req_addr_i   (req_addr_i),
    .req_data_i   (req_data_i),
    .req_mask_i   (req_mask_i),
    .resp_v_o     (resp_v_o),
    .resp_data_o  (resp_data_o)
  );

  always #2 clk_i = ~clk_i;

  always @(posedge clk_i) cycle <= cycle + 1;

  function automatic logic [31:0] next_rand();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  function automatic logic [`DMEM_ADDR_WIDTH-1:0] byte_addr(input int w, input int o);
    return WIN + 10'(4 * w + o);
  endfunction

  // One request on the falling edge, accepted at the next rising edge
  task automatic send(input mem_op_pkg::opcode_e op, input logic [`DMEM_ADDR_WIDTH-1:0] addr,
                      input logic [31:0] data, input logic [3:0] mask);
    @(negedge clk_i);
    req_v_i      = 1'b1;
    req_opcode_i = op;
    req_addr_i   = addr;
    req_data_i   = data;
    req_mask_i   = mask;
    exp_q.push_back(model_access(op, addr, data, mask));
    due_q.push_back(cycle + 3);
  endtask

  task automatic idle();
    @(negedge clk_i);
    req_v_i = 1'b0;
  endtask

  ////////////////////
  // Response checker

  always @(posedge clk_i) begin
    if (!reset_i && resp_v_o) begin
      if (exp_q.size() == 0) begin
        $display("Response at time %0t arrived with no request outstanding", $time);
        protocol_errors++;
      end else begin
        exp_data = exp_q.pop_front();
        exp_due  = due_q.pop_front();
        checked++;
        if (resp_data_o !== exp_data) begin
          $display("CHECK FAILED t=%0t: response %h, expected %h", $time, resp_data_o, exp_data);
          value_errors++;
        end
        if (cycle != exp_due) begin
          $display("CHECK FAILED t=%0t: response in cycle %0d, expected in cycle %0d",
                   $time, cycle, exp_due);
          protocol_errors++;
        end
      end
    end
  end

  ////////////////////
  // Stimulus

  initial begin
    int n;
    reset_i      = 1'b1;
    req_v_i      = 1'b0;
    req_opcode_i = '0;
    req_addr_i   = '0;
    req_data_i   = '0;
    req_mask_i   = '0;
    for (int w = 0; w < `DMEM_WORDS; w++) shadow[w] = '0;
    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    reset_i = 1'b0;

    for (int w = 0; w < 8; w++) send(mem_op_pkg::LW, byte_addr(w, 0), '0, '0);

    // Partial stores merged into a known word
    for (int o = 0; o < 4; o++) begin
      send(mem_op_pkg::SW, byte_addr(1, 0), 32'h8899_aabb, '0);
      send(mem_op_pkg::SB, byte_addr(1, o), 32'h5a5a_5a00 | 32'(o), '0);
      send(mem_op_pkg::LW, byte_addr(1, 0), '0, '0);
      send(mem_op_pkg::SH, byte_addr(2, o), 32'hc3d4_e5f6 + 32'(o), '0);
      send(mem_op_pkg::LW, byte_addr(2, 0), '0, '0);
    end
    send(mem_op_pkg::SM, byte_addr(3, 0), 32'h0102_0304, 4'b1010);
    send(mem_op_pkg::LW, byte_addr(3, 0), '0, '0);

    // Sign bits set in lanes 0, 2 and 3 and in the upper half
    send(mem_op_pkg::SW, byte_addr(4, 0), 32'h80ff_7f81, '0);
    for (int o = 0; o < 4; o++) begin
      send(mem_op_pkg::LB, byte_addr(4, o), '0, '0);
      send(mem_op_pkg::LBU, byte_addr(4, o), '0, '0);
      send(mem_op_pkg::LH, byte_addr(4, o), '0, '0);
      send(mem_op_pkg::LHU, byte_addr(4, o), '0, '0);
    end
    for (int m = 0; m < 16; m++) send(mem_op_pkg::LM, byte_addr(4, 0), '0, 4'(m));

    for (int a = 0; a < 9; a++) begin
      send(mem_op_pkg::SW, byte_addr(5, 0), 32'h8000_0010, '0);
      send(amo_ops[a], byte_addr(5, 0), 32'h0000_0020, '0);
      send(mem_op_pkg::LW, byte_addr(5, 0), '0, '0);
      send(mem_op_pkg::SW, byte_addr(6, 0), 32'h0000_0030, '0);
      send(amo_ops[a], byte_addr(6, 0), 32'hffff_fff0, '0);
      send(mem_op_pkg::LW, byte_addr(6, 0), '0, '0);
    end

    // Back to back on one word
    send(mem_op_pkg::SB, byte_addr(7, 3), 32'h0000_00e7, '0);
    send(mem_op_pkg::LW, byte_addr(7, 0), '0, '0);
    repeat (3) send(mem_op_pkg::AMOADD_W, byte_addr(7, 1), 32'h0101_0101, '0);
    send(mem_op_pkg::LW, byte_addr(7, 0), '0, '0);
    send(mem_op_pkg::SH, byte_addr(7, 2), 32'h0000_beef, '0);
    send(mem_op_pkg::AMOXOR_W, byte_addr(7, 0), 32'hffff_0000, '0);
    send(mem_op_pkg::LB, byte_addr(7, 3), '0, '0);

    n = 0;
    while (n < RAND_REQS) begin
      if (next_rand() % 10 < 7) begin
        send(mem_op_pkg::opcode_e'(5'(next_rand() % 19)),
             byte_addr(int'(next_rand() % 8), int'(next_rand() % 4)),
             next_rand(), 4'(next_rand()));
        n++;
      end else begin
        idle();
      end
    end
    idle();

    for (int i = 0; i < 10 && exp_q.size() != 0; i++) @(negedge clk_i);
    repeat (4) @(negedge clk_i);  // Catch any extra response
    if (exp_q.size() != 0) begin
      $display("%0d expected responses never arrived", exp_q.size());
      protocol_errors += exp_q.size();
    end
    $display("Errors: %0d value, %0d protocol, %0d responses checked",
             value_errors, protocol_errors, checked);
    if (value_errors + protocol_errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  initial begin
    #(MAX_CYCLES * 4);
    $display("Timeout after %0d cycles, the run did not finish", MAX_CYCLES);
    $display("Errors: %0d value, %0d protocol, %0d responses checked",
             value_errors, protocol_errors, checked);
    $display("Simulation failed");
    $finish;
  end

endmodule
